// File: isf_support.f
+incdir+source
source/isf_stream_pkg.sv
source/isf_ctl_pkg.sv
source/isf_flow_ctl.sv
source/isf_ib_parser.sv
source/isf_ob_monitor.sv
source/isf_support.sv
verification/isf_support_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; a failing test exits non-zero.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f isf_support.f \
  --top-module isf_support_tb \
  --Mdir obj_dir -o isf_support_sim

./obj_dir/isf_support_sim

// File: source/isf_consts.svh
`ifndef ISF_CONSTS_SVH
`define ISF_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// isf fifo geometry
// ~~~~~~~~~~~~~~~~~~~~
`define ISF_FIFO_ENTRIES 128 // capacity of the isf fifo in entries.
`define ISF_DEPTH_W      8   // holds a depth count from 0 to 128.

// ~~~~~~~~~~~~~~~~~~~~
// stream layout
// ~~~~~~~~~~~~~~~~~~~~
`define ISF_DWIDTH       64
`define ISF_TLV_TYPE_W   8   // type sits in the low bits of a start-of-frame beat.

// ~~~~~~~~~~~~~~~~~~~~
// supervision
// ~~~~~~~~~~~~~~~~~~~~
`define ISF_WMARK_STEP   8   // select value s means (s+1) steps of entries.
`define ISF_STALL_CNT_W  32

`endif

// File: source/isf_ctl_pkg.sv
`include "isf_consts.svh"

package isf_ctl_pkg;

  // codes 3 and up are not assigned and behave like NORMAL.
  typedef enum logic [1:0] {
    NORMAL   = 2'd0,
    BLK_RDWR = 2'd1,
    BLK_RD   = 2'd2
  } isf_debug_mode_e;

  typedef struct packed {
    logic [2:0]                  use_wmark_sel;
    logic [2:0]                  req_wmark_sel;
    isf_debug_mode_e             debug_mode;
    logic                        force_ib_bp;
    logic                        sys_stall_en;
    logic [`ISF_STALL_CNT_W-1:0] stall_limit;
  } isf_ctl_t;

  // every field is a one-cycle strobe except mask_debug, which is a level.
  typedef struct packed {
    logic sup_rqe_rx;
    logic sup_cqe_rx;
    logic sup_cqe_exit;
    logic sys_stall_intr;
    logic mask_debug;
  } isf_events_t;

endpackage

// File: source/isf_flow_ctl.sv
`timescale 1ns/1ps
`include "isf_consts.svh"

module isf_flow_ctl
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  isf_ctl_pkg::isf_ctl_t   ctl,
  input  logic [`ISF_DEPTH_W-1:0] fifo_depth,
  input  logic                    slv_empty,
  input  logic                    tlvp_fifo_afull,
  output logic                    slv_rd,
  output logic                    fifo_hw_wr,
  output logic                    fifo_hw_rd,
  output logic                    tlvp_fifo_wr
);
  import isf_ctl_pkg::*;

  localparam int DEPTH_W = `ISF_DEPTH_W;

  typedef enum logic {FULL_IDLE, FULL_BP} full_st_e;

  full_st_e           full_st;
  logic [DEPTH_W-1:0] use_wmark;
  logic [DEPTH_W-1:0] req_wmark;
  logic [DEPTH_W-1:0] set_depth;
  logic [DEPTH_W-1:0] clr_depth;
  logic               set_hit;
  logic               clr_hit;
  logic               fifo_full;
  logic               rd_ok;

  function automatic logic [DEPTH_W-1:0] wmark_entries(input logic [2:0] sel);
    wmark_entries = (DEPTH_W'(sel) + DEPTH_W'(1)) * DEPTH_W'(`ISF_WMARK_STEP);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // watermark hysteresis
  // ~~~~~~~~~~~~~~~~~~~~
  assign use_wmark = wmark_entries(ctl.use_wmark_sel);
  assign req_wmark = wmark_entries(ctl.req_wmark_sel);
  assign set_depth = DEPTH_W'(`ISF_FIFO_ENTRIES) - use_wmark;
  assign clr_depth = DEPTH_W'(`ISF_FIFO_ENTRIES) - (use_wmark + req_wmark); // sum tops out at 128.
  assign set_hit   = fifo_depth >= set_depth;
  assign clr_hit   = fifo_depth <= clr_depth;
  assign fifo_full = (full_st == FULL_BP);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full_st <= FULL_IDLE;
    end
    else if (full_st == FULL_IDLE)
    begin
      if (set_hit)
      begin
        full_st <= FULL_BP;
      end
    end
    else if (clr_hit)
    begin
      full_st <= FULL_IDLE; // hold back-pressure until the lower mark is reached.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // debug gating
  // ~~~~~~~~~~~~~~~~~~~~
  assign rd_ok  = (fifo_depth != '0) && !tlvp_fifo_afull;
  assign slv_rd = fifo_hw_wr; // every isf write pops the slave fifo.

  always_comb
  begin
    case (ctl.debug_mode)
      BLK_RDWR:
      begin
        fifo_hw_wr = 1'b0;
        fifo_hw_rd = 1'b0;
      end
      BLK_RD:
      begin
        fifo_hw_wr = !slv_empty && !fifo_full;
        fifo_hw_rd = 1'b0;
      end
      default:
      begin
        fifo_hw_wr = !slv_empty && !fifo_full && !ctl.force_ib_bp;
        fifo_hw_rd = rd_ok;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tlvp_fifo_wr <= 1'b0;
    end
    else
    begin
      tlvp_fifo_wr <= fifo_hw_rd && !tlvp_fifo_afull; // read data lands one cycle later.
    end
  end

endmodule

// File: source/isf_ib_parser.sv
`timescale 1ns/1ps
`include "isf_consts.svh"

module isf_ib_parser
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  isf_stream_pkg::isf_beat_t slv_beat,
  input  logic                     slv_rd,
  output logic                     sup_rqe_rx,
  output logic                     sup_cqe_rx,
  output logic                     mask_debug
);
  import isf_stream_pkg::*;

  localparam int TYPE_W = `ISF_TLV_TYPE_W;

  ib_par_st_e par_st;
  ib_par_st_e par_st_nxt;
  tlv_type_e  beat_type;
  logic       accepted;
  logic       sof_acc;
  logic       rqe_nxt;
  logic       cqe_nxt;

  assign accepted  = slv_rd && slv_beat.tvalid;
  assign sof_acc   = accepted && slv_beat.sof;
  assign beat_type = tlv_type_e'(slv_beat.tdata[TYPE_W-1:0]);

  always_comb
  begin
    par_st_nxt = par_st;
    rqe_nxt    = 1'b0;
    cqe_nxt    = 1'b0;
    case (par_st)
      IB_IDLE:
      begin
        if (sof_acc && (beat_type == RQE))
        begin
          rqe_nxt    = 1'b1;
          par_st_nxt = IB_RQE_FOUND;
        end
      end
      IB_RQE_FOUND:
      begin
        if (sof_acc && (beat_type == CQE))
        begin
          cqe_nxt    = 1'b1;
          par_st_nxt = IB_CQE_FOUND;
        end
        else if (sof_acc && (beat_type == CMD))
        begin
          par_st_nxt = IB_CMD_FOUND;
        end
      end
      IB_CMD_FOUND:
      begin
        if (accepted)
        begin
          par_st_nxt = IB_RQE_FOUND; // the command spans a single beat.
        end
      end
      IB_CQE_FOUND:
      begin
        if (accepted && slv_beat.eof)
        begin
          par_st_nxt = IB_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      par_st     <= IB_IDLE;
      sup_rqe_rx <= 1'b0;
      sup_cqe_rx <= 1'b0;
    end
    else
    begin
      par_st     <= par_st_nxt;
      sup_rqe_rx <= rqe_nxt;
      sup_cqe_rx <= cqe_nxt;
    end
  end

  assign mask_debug = (par_st == IB_CMD_FOUND);

endmodule

// File: source/isf_ob_monitor.sv
`timescale 1ns/1ps
`include "isf_consts.svh"

module isf_ob_monitor
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  isf_stream_pkg::isf_beat_t   ob_beat,
  input  logic                        ob_ready,
  input  logic                        sys_stall_en,
  input  logic [`ISF_STALL_CNT_W-1:0] stall_limit,
  output logic                        sup_cqe_exit,
  output logic                        sys_stall_intr
);
  import isf_stream_pkg::*;

  localparam int TYPE_W = `ISF_TLV_TYPE_W;
  localparam int CNT_W  = `ISF_STALL_CNT_W;

  ob_par_st_e       ob_st;
  stall_st_e        stall_st;
  tlv_type_e        beat_type;
  logic [CNT_W-1:0] stall_cnt;
  logic             xfer;
  logic             cqe_sof;
  logic             stalled;
  logic             limit_hit;

  assign xfer      = ob_beat.tvalid && ob_ready;
  assign beat_type = tlv_type_e'(ob_beat.tdata[TYPE_W-1:0]);
  assign cqe_sof   = xfer && ob_beat.sof && (beat_type == CQE);
  assign stalled   = ob_beat.tvalid && !ob_ready && sys_stall_en;
  assign limit_hit = (stall_cnt == stall_limit);

  // ~~~~~~~~~~~~~~~~~~~~
  // cqe exit detection
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ob_st        <= OB_IDLE;
      sup_cqe_exit <= 1'b0;
    end
    else
    begin
      sup_cqe_exit <= 1'b0;
      if (ob_st == OB_IDLE)
      begin
        if (cqe_sof && ob_beat.eof)
        begin
          sup_cqe_exit <= 1'b1; // single-beat cqe frame.
        end
        else if (cqe_sof)
        begin
          ob_st <= OB_CQE_FOUND;
        end
      end
      else if (xfer && ob_beat.eof)
      begin
        sup_cqe_exit <= 1'b1;
        ob_st        <= OB_IDLE;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // stall watchdog
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      stall_st       <= STALL_IDLE;
      stall_cnt      <= '0;
      sys_stall_intr <= 1'b0;
    end
    else
    begin
      sys_stall_intr <= 1'b0;
      if ((stall_st == STALL_CNT) && limit_hit)
      begin
        sys_stall_intr <= 1'b1; // restart the count after every interrupt.
        stall_cnt      <= '0;
        stall_st       <= STALL_IDLE;
      end
      else if (stalled)
      begin
        stall_cnt <= stall_cnt + CNT_W'(1);
        stall_st  <= STALL_CNT;
      end
      else
      begin
        stall_cnt <= '0;
        stall_st  <= STALL_IDLE;
      end
    end
  end

endmodule

// File: source/isf_stream_pkg.sv
`include "isf_consts.svh"

package isf_stream_pkg;

  typedef struct packed {
    logic                   tvalid;
    logic                   sof;    // start of frame.
    logic                   eof;    // end of frame.
    logic [`ISF_DWIDTH-1:0] tdata;
  } isf_beat_t;

  typedef enum logic [`ISF_TLV_TYPE_W-1:0] {
    RQE  = 8'h00,
    CMD  = 8'h01,
    KEY  = 8'h02,
    PHD  = 8'h03,
    PFD  = 8'h04,
    DATA = 8'h05,
    FTR  = 8'h06,
    LZ77 = 8'h07,
    STAT = 8'h08,
    CQE  = 8'h09
  } tlv_type_e;

  typedef enum logic [1:0] {
    IB_IDLE,
    IB_RQE_FOUND,
    IB_CMD_FOUND,
    IB_CQE_FOUND
  } ib_par_st_e;

  typedef enum logic {OB_IDLE, OB_CQE_FOUND} ob_par_st_e;

  typedef enum logic {STALL_IDLE, STALL_CNT} stall_st_e;

endpackage

// File: source/isf_support.sv
`timescale 1ns/1ps
`include "isf_consts.svh"

module isf_support
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  isf_ctl_pkg::isf_ctl_t     ctl,
  input  isf_stream_pkg::isf_beat_t slv_beat,
  input  logic                      slv_empty,
  input  logic [`ISF_DEPTH_W-1:0]   fifo_depth,
  input  logic                      tlvp_fifo_afull,
  input  isf_stream_pkg::isf_beat_t ob_beat,
  input  logic                      ob_ready,
  output logic                      slv_rd,
  output logic                      fifo_hw_wr,
  output logic                      fifo_hw_rd,
  output logic                      tlvp_fifo_wr,
  output isf_ctl_pkg::isf_events_t  events
);

  logic sup_rqe_rx;
  logic sup_cqe_rx;
  logic sup_cqe_exit;
  logic sys_stall_intr;
  logic mask_debug;

  isf_flow_ctl isf_flow_ctl_i
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctl             (ctl),
    .fifo_depth      (fifo_depth),
    .slv_empty       (slv_empty),
    .tlvp_fifo_afull (tlvp_fifo_afull),
    .slv_rd          (slv_rd),
    .fifo_hw_wr      (fifo_hw_wr),
    .fifo_hw_rd      (fifo_hw_rd),
    .tlvp_fifo_wr    (tlvp_fifo_wr)
  );

  isf_ib_parser isf_ib_parser_i
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .slv_beat   (slv_beat),
    .slv_rd     (slv_rd), // a beat is taken only when the flow control pops it.
    .sup_rqe_rx (sup_rqe_rx),
    .sup_cqe_rx (sup_cqe_rx),
    .mask_debug (mask_debug)
  );

  isf_ob_monitor isf_ob_monitor_i
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .ob_beat        (ob_beat),
    .ob_ready       (ob_ready),
    .sys_stall_en   (ctl.sys_stall_en),
    .stall_limit    (ctl.stall_limit),
    .sup_cqe_exit   (sup_cqe_exit),
    .sys_stall_intr (sys_stall_intr)
  );

  assign events = '{
    sup_rqe_rx:     sup_rqe_rx,
    sup_cqe_rx:     sup_cqe_rx,
    sup_cqe_exit:   sup_cqe_exit,
    sys_stall_intr: sys_stall_intr,
    mask_debug:     mask_debug
  };

endmodule

// File: verification/isf_support_tb.sv
`timescale 1ns/1ps
`include "isf_consts.svh"

module isf_support_tb;
  import isf_stream_pkg::*;
  import isf_ctl_pkg::*;

  localparam int CLK_HALF   = 50;
  localparam int DRIVE_DLY  = 1;
  localparam int CHECK_DLY  = 98; // samples just before the next rising edge.
  localparam int RST_CYCLES = 10;
  // reset, four sweeps of 130, gating, inbound, outbound and 16 stall runs of up to 36.
  localparam int TEST_CYCLES    = RST_CYCLES + 520 + 300 + 500 + 400 + 576 + 10;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  typedef struct packed {
    logic slv_rd;
    logic fifo_hw_wr;
    logic fifo_hw_rd;
    logic tlvp_fifo_wr;
  } flow_t;

  logic                        clk;
  logic                        rst_n;
  isf_ctl_t                    ctl;
  isf_beat_t                   slv_beat;
  logic                        slv_empty;
  logic [`ISF_DEPTH_W-1:0]     fifo_depth;
  logic                        tlvp_fifo_afull;
  isf_beat_t                   ob_beat;
  logic                        ob_ready;
  logic                        slv_rd;
  logic                        fifo_hw_wr;
  logic                        fifo_hw_rd;
  logic                        tlvp_fifo_wr;
  isf_events_t                 events;
  int                          seed;
  int                          cycle_cnt;
  logic                        m_full;
  ib_par_st_e                  m_ib_st;
  logic                        m_rqe;
  logic                        m_cqe;
  logic                        m_ob_busy;
  logic                        m_exit;
  logic [`ISF_STALL_CNT_W-1:0] m_cnt;
  logic                        m_intr;
  logic                        m_tlvp_wr;
  logic                        exp_wr;
  logic                        exp_rd;
  logic                        ob_stalled;
  flow_t                       exp_flow;
  flow_t                       got_flow;
  isf_events_t                 exp_ev;

  isf_support isf_support_i
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctl             (ctl),
    .slv_beat        (slv_beat),
    .slv_empty       (slv_empty),
    .fifo_depth      (fifo_depth),
    .tlvp_fifo_afull (tlvp_fifo_afull),
    .ob_beat         (ob_beat),
    .ob_ready        (ob_ready),
    .slv_rd          (slv_rd),
    .fifo_hw_wr      (fifo_hw_wr),
    .fifo_hw_rd      (fifo_hw_rd),
    .tlvp_fifo_wr    (tlvp_fifo_wr),
    .events          (events)
  );

  always #CLK_HALF clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic full_next(input logic full, input logic [`ISF_DEPTH_W-1:0] depth,
                                     input isf_ctl_t c);
    int use_n;
    int req_n;
    int d;
    use_n = (int'(c.use_wmark_sel) + 1) * `ISF_WMARK_STEP;
    req_n = (int'(c.req_wmark_sel) + 1) * `ISF_WMARK_STEP;
    d     = int'(depth);
    if (!full)
      full_next = (d >= `ISF_FIFO_ENTRIES - use_n);
    else
      full_next = (d > `ISF_FIFO_ENTRIES - use_n - req_n); // stays set above the low mark.
  endfunction

  function automatic logic wr_allowed(input isf_debug_mode_e mode, input logic empty,
                                      input logic full, input logic force_bp);
    case (mode)
      BLK_RDWR: wr_allowed = 1'b0;
      BLK_RD:   wr_allowed = !empty && !full;
      default:  wr_allowed = !empty && !full && !force_bp;
    endcase
  endfunction

  function automatic logic rd_allowed(input isf_debug_mode_e mode,
                                      input logic [`ISF_DEPTH_W-1:0] depth, input logic afull);
    if ((mode == BLK_RDWR) || (mode == BLK_RD))
      rd_allowed = 1'b0;
    else
      rd_allowed = (depth != '0) && !afull;
  endfunction

  function automatic ib_par_st_e ib_next(input ib_par_st_e st, input isf_beat_t b,
                                         input logic acc);
    logic sof_acc;
    sof_acc = acc && b.sof;
    ib_next = st;
    case (st)
      IB_IDLE:
        if (sof_acc && (b.tdata[7:0] == RQE))
          ib_next = IB_RQE_FOUND;
      IB_RQE_FOUND:
        if (sof_acc && (b.tdata[7:0] == CQE))
          ib_next = IB_CQE_FOUND;
        else if (sof_acc && (b.tdata[7:0] == CMD))
          ib_next = IB_CMD_FOUND;
      IB_CMD_FOUND:
        if (acc)
          ib_next = IB_RQE_FOUND;
      IB_CQE_FOUND:
        if (acc && b.eof)
          ib_next = IB_IDLE;
    endcase
  endfunction

  function automatic logic ob_exit(input logic busy, input isf_beat_t b, input logic ready);
    logic xfer;
    xfer = b.tvalid && ready;
    if (!busy)
      ob_exit = xfer && b.sof && b.eof && (b.tdata[7:0] == CQE);
    else
      ob_exit = xfer && b.eof;
  endfunction

  function automatic logic ob_busy_next(input logic busy, input isf_beat_t b, input logic ready);
    logic xfer;
    xfer = b.tvalid && ready;
    if (!busy)
      ob_busy_next = xfer && b.sof && !b.eof && (b.tdata[7:0] == CQE);
    else
      ob_busy_next = !(xfer && b.eof);
  endfunction

  function automatic logic stall_fires(input logic [`ISF_STALL_CNT_W-1:0] cnt,
                                       input logic [`ISF_STALL_CNT_W-1:0] limit);
    stall_fires = (cnt == limit) && (limit != '0);
  endfunction

  function automatic logic [`ISF_STALL_CNT_W-1:0] stall_next(
    input logic [`ISF_STALL_CNT_W-1:0] cnt, input logic stalled,
    input logic [`ISF_STALL_CNT_W-1:0] limit);
    if (stall_fires(cnt, limit))
      stall_next = '0;
    else if (stalled)
      stall_next = cnt + 32'd1;
    else
      stall_next = '0;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // checking
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_flow(input flow_t got, input flow_t exp);
    if (got !== exp)
      abort_run($sformatf("ERR %0t: flow strobes (rd,wr,hw_rd,tlvp_wr) expected %b got %b",
                          $time, exp, got));
  endtask

  task automatic check_events(input isf_events_t got, input isf_events_t exp);
    if (got !== exp)
      abort_run($sformatf("ERR %0t: events (rqe,cqe,exit,stall,mask) expected %b got %b",
                          $time, exp, got));
  endtask

  always @(posedge clk)
  begin
    #CHECK_DLY;
    exp_wr                = wr_allowed(ctl.debug_mode, slv_empty, m_full, ctl.force_ib_bp);
    exp_rd                = rd_allowed(ctl.debug_mode, fifo_depth, tlvp_fifo_afull);
    exp_flow.slv_rd       = exp_wr;
    exp_flow.fifo_hw_wr   = exp_wr;
    exp_flow.fifo_hw_rd   = exp_rd;
    exp_flow.tlvp_fifo_wr = m_tlvp_wr;
    got_flow.slv_rd       = slv_rd;
    got_flow.fifo_hw_wr   = fifo_hw_wr;
    got_flow.fifo_hw_rd   = fifo_hw_rd;
    got_flow.tlvp_fifo_wr = tlvp_fifo_wr;
    check_flow(got_flow, exp_flow);
    exp_ev.sup_rqe_rx     = m_rqe;
    exp_ev.sup_cqe_rx     = m_cqe;
    exp_ev.sup_cqe_exit   = m_exit;
    exp_ev.sys_stall_intr = m_intr;
    exp_ev.mask_debug     = (m_ib_st == IB_CMD_FOUND);
    check_events(events, exp_ev);
    if (!rst_n)
    begin
      m_full    = 1'b0;
      m_ib_st   = IB_IDLE;
      m_rqe     = 1'b0;
      m_cqe     = 1'b0;
      m_ob_busy = 1'b0;
      m_exit    = 1'b0;
      m_cnt     = '0;
      m_intr    = 1'b0;
      m_tlvp_wr = 1'b0;
    end
    else
    begin
      m_rqe      = (m_ib_st == IB_IDLE) &&
                   (ib_next(m_ib_st, slv_beat, exp_wr && slv_beat.tvalid) == IB_RQE_FOUND);
      m_cqe      = (m_ib_st == IB_RQE_FOUND) &&
                   (ib_next(m_ib_st, slv_beat, exp_wr && slv_beat.tvalid) == IB_CQE_FOUND);
      m_ib_st    = ib_next(m_ib_st, slv_beat, exp_wr && slv_beat.tvalid);
      m_exit     = ob_exit(m_ob_busy, ob_beat, ob_ready);
      m_ob_busy  = ob_busy_next(m_ob_busy, ob_beat, ob_ready);
      ob_stalled = ob_beat.tvalid && !ob_ready && ctl.sys_stall_en;
      m_intr     = stall_fires(m_cnt, ctl.stall_limit);
      m_cnt      = stall_next(m_cnt, ob_stalled, ctl.stall_limit);
      m_full     = full_next(m_full, fifo_depth, ctl);
      m_tlvp_wr  = exp_rd && !tlvp_fifo_afull;
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
      abort_run($sformatf("timeout: the tests did not finish within %0d cycles",
                          TIMEOUT_CYCLES));
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic random_beat(output isf_beat_t b);
    logic [31:0] r;
    logic [31:0] hi;
    logic [7:0]  t;
    r  = $random(seed);
    hi = $random(seed);
    case (r[7:6])
      2'd0:    t = RQE;
      2'd1:    t = CMD;
      2'd2:    t = CQE;
      default: t = DATA;
    endcase
    b.tvalid = (r[2:0] != 3'd0);
    b.sof    = r[3];
    b.eof    = r[4];
    b.tdata  = {hi, r[31:8], t};
  endtask

  task automatic sweep_wmarks(input logic [2:0] use_sel, input logic [2:0] req_sel);
    int d;
    ctl.use_wmark_sel = use_sel;
    ctl.req_wmark_sel = req_sel;
    for (d = 0; d <= `ISF_FIFO_ENTRIES; d += 2)
    begin
      fifo_depth = 8'(d);
      next_cycle();
    end
    for (d = `ISF_FIFO_ENTRIES; d >= 0; d -= 2)
    begin
      fifo_depth = 8'(d);
      next_cycle();
    end
  endtask

  task automatic random_gating(input int cycles);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++)
    begin
      r = $random(seed);
      ctl.debug_mode  = isf_debug_mode_e'(r[1:0]); // code 3 is exercised as well.
      ctl.force_ib_bp = r[2];
      slv_empty       = r[3];
      tlvp_fifo_afull = r[4];
      fifo_depth      = r[15] ? 8'd0 : {1'b0, r[14:8]};
      random_beat(slv_beat);
      next_cycle();
    end
  endtask

  task automatic random_inbound(input int cycles);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++)
    begin
      r = $random(seed);
      slv_empty = (r[1:0] == 2'd0); // gaps in acceptance.
      random_beat(slv_beat);
      next_cycle();
    end
  endtask

  task automatic random_outbound(input int cycles);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++)
    begin
      r = $random(seed);
      ob_ready = (r[1:0] != 2'd0);
      random_beat(ob_beat);
      next_cycle();
    end
  endtask

  task automatic stall_runs(input int runs);
    logic [31:0] r;
    int          len;
    int          gap;
    for (int i = 0; i < runs; i++)
    begin
      r   = $random(seed);
      len = int'(r[10:6]) + 1;
      gap = int'(r[13:12]) + 1;
      ctl.stall_limit  = 32'(r[3:0]) + 32'd1;
      ctl.sys_stall_en = (r[5:4] != 2'd0);
      ob_beat          = '0;
      ob_beat.tvalid   = 1'b1;
      ob_ready         = 1'b0;
      repeat (len) next_cycle();
      ob_beat.tvalid = r[11];
      ob_ready       = 1'b1;
      repeat (gap) next_cycle();
    end
  endtask

  initial
  begin
    seed            = 20071;
    cycle_cnt       = 0;
    clk             = 1'b0;
    rst_n           = 1'b0;
    ctl             = '0;
    ctl.stall_limit = 32'd8;
    slv_beat        = '0;
    slv_empty       = 1'b1;
    fifo_depth      = '0;
    tlvp_fifo_afull = 1'b0;
    ob_beat         = '0;
    ob_ready        = 1'b1;
    m_full          = 1'b0; // model starts in its reset state.
    m_ib_st         = IB_IDLE;
    m_rqe           = 1'b0;
    m_cqe           = 1'b0;
    m_ob_busy       = 1'b0;
    m_exit          = 1'b0;
    m_cnt           = '0;
    m_intr          = 1'b0;
    m_tlvp_wr       = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    repeat (2) next_cycle();
    slv_empty = 1'b0;
    sweep_wmarks(3'd0, 3'd0);
    sweep_wmarks(3'd3, 3'd2);
    sweep_wmarks(3'd7, 3'd7);
    sweep_wmarks(3'd5, 3'd1);
    random_gating(300);
    ctl.debug_mode  = NORMAL;
    ctl.force_ib_bp = 1'b0;
    fifo_depth      = '0;
    tlvp_fifo_afull = 1'b0;
    random_inbound(500);
    slv_empty        = 1'b1;
    slv_beat         = '0;
    ctl.sys_stall_en = 1'b1;
    random_outbound(400);
    stall_runs(16);
    ob_beat = '0;
    repeat (3) next_cycle();
    $display("All tests passed");
    $finish;
  end

endmodule
